/* mini_mcu.f */
src/mini_mcu_pkg.sv
src/instr_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/mini_core.sv
src/mm_ram.sv
src/mini_mcu.sv
test/mini_mcu_checker.sv
test/mini_mcu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mini mcu testbench with Verilator
verilator --binary --assert --top-module mini_mcu_tb -f mini_mcu.f -o mini_mcu_sim \
  && ./obj_dir/mini_mcu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
test -f sim.log || exit 1
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

/* test/mini_mcu_tb.sv */
// mini mcu testbench
`default_nettype none

module mini_mcu_tb;

  localparam int ROWS       = 7;
  localparam int LOAD_WORDS = 8;
  localparam int RAM_WORDS  = 256;
  // per row: load words, reset cycles, eight instructions at load latency, margin
  localparam int TIMEOUT_CYCLES = ROWS * (LOAD_WORDS + 3 + 8 * 3 + 20);

  logic                clk;
  logic                rst_n;
  logic                fetch_enable;
  logic                prog_we;
  mini_mcu_pkg::addr_t prog_addr;
  mini_mcu_pkg::word_t prog_wdata;
  logic                exit_valid;
  mini_mcu_pkg::word_t exit_value;
  logic                tests_passed;
  logic                tests_failed;
  mini_mcu_pkg::word_t exp_value;
  logic                exp_pass;
  int                  rows_done;
  int                  rows_passed;
  int                  rows_failed;
  int                  cycle_count;

  mini_mcu_pkg::word_t prog_tab [ROWS][LOAD_WORDS];
  mini_mcu_pkg::word_t exp_value_tab [ROWS];
  logic                exp_pass_tab [ROWS];

  mini_mcu #(
    .BOOT_ADDR (16'h0000),
    .RAM_WORDS (RAM_WORDS)
  ) mini_mcu_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_enable_i (fetch_enable),
    .prog_we_i      (prog_we),
    .prog_addr_i    (prog_addr),
    .prog_wdata_i   (prog_wdata),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value),
    .tests_passed_o (tests_passed),
    .tests_failed_o (tests_failed)
  );

  mini_mcu_checker exit_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_enable_i (fetch_enable),
    .exit_valid_i   (exit_valid),
    .exit_value_i   (exit_value),
    .tests_passed_i (tests_passed),
    .tests_failed_i (tests_failed),
    .exp_value_i    (exp_value),
    .exp_pass_i     (exp_pass),
    .rows_done_o    (rows_done),
    .rows_passed_o  (rows_passed),
    .rows_failed_o  (rows_failed)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // op rd rs1 rs2 imm, the immediate keeps its low 16 bits
  function automatic mini_mcu_pkg::word_t encode(input mini_mcu_pkg::opcode_e op,
      input int rd, input int rs1, input int rs2, input int imm);
    mini_mcu_pkg::word_t w;
    w        = '0;
    w[31:28] = op;
    w[27:25] = rd[2:0];
    w[24:22] = rs1[2:0];
    w[21:19] = rs2[2:0];
    w[15:0]  = imm[15:0];
    return w;
  endfunction

  task automatic build_programs();
    for (int r = 0; r < ROWS; r++) begin
      for (int i = 0; i < LOAD_WORDS; i++) begin
        prog_tab[r][i] = encode(mini_mcu_pkg::OP_BEQ, 0, 0, 0, 0);
      end
    end
    // 5 + 3, exit at 'hFF00
    prog_tab[0][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, 5);
    prog_tab[0][1] = encode(mini_mcu_pkg::OP_ADDI, 2, 0, 0, 3);
    prog_tab[0][2] = encode(mini_mcu_pkg::OP_ADD, 3, 1, 2, 0);
    prog_tab[0][3] = encode(mini_mcu_pkg::OP_SW, 0, 0, 3, 'hFF00);
    // -2 - 7
    prog_tab[1][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, -2);
    prog_tab[1][1] = encode(mini_mcu_pkg::OP_ADDI, 2, 0, 0, 7);
    prog_tab[1][2] = encode(mini_mcu_pkg::OP_SUB, 3, 1, 2, 0);
    prog_tab[1][3] = encode(mini_mcu_pkg::OP_SW, 0, 0, 3, 'hFF00);
    // (0ff0 | 00ff) ^ (0ff0 & 00ff)
    prog_tab[2][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, 'h0FF0);
    prog_tab[2][1] = encode(mini_mcu_pkg::OP_ADDI, 2, 0, 0, 'h00FF);
    prog_tab[2][2] = encode(mini_mcu_pkg::OP_AND, 3, 1, 2, 0);
    prog_tab[2][3] = encode(mini_mcu_pkg::OP_OR, 4, 1, 2, 0);
    prog_tab[2][4] = encode(mini_mcu_pkg::OP_XOR, 5, 4, 3, 0);
    prog_tab[2][5] = encode(mini_mcu_pkg::OP_SW, 0, 0, 5, 'hFF00);
    // writes into x0 are dropped
    prog_tab[3][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, 9);
    prog_tab[3][1] = encode(mini_mcu_pkg::OP_ADD, 0, 1, 1, 0);
    prog_tab[3][2] = encode(mini_mcu_pkg::OP_ADDI, 0, 1, 0, 4);
    prog_tab[3][3] = encode(mini_mcu_pkg::OP_SW, 0, 0, 0, 'hFF00);
    // store at RAM_WORDS + 20 aliases word 20
    prog_tab[4][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, 'h1234);
    prog_tab[4][1] = encode(mini_mcu_pkg::OP_SW, 0, 0, 1, RAM_WORDS + 20);
    prog_tab[4][2] = encode(mini_mcu_pkg::OP_LW, 2, 0, 0, 20);
    prog_tab[4][3] = encode(mini_mcu_pkg::OP_SW, 0, 0, 2, 'hFF00);
    // three passes of x2 += 3
    prog_tab[5][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, 3);
    prog_tab[5][1] = encode(mini_mcu_pkg::OP_ADDI, 2, 2, 0, 3);
    prog_tab[5][2] = encode(mini_mcu_pkg::OP_ADDI, 1, 1, 0, -1);
    prog_tab[5][3] = encode(mini_mcu_pkg::OP_BEQ, 0, 1, 0, 2);
    prog_tab[5][4] = encode(mini_mcu_pkg::OP_BEQ, 0, 0, 0, -3);
    prog_tab[5][5] = encode(mini_mcu_pkg::OP_SW, 0, 0, 2, 'hFF00);
    // taken branch skips the write of x3
    prog_tab[6][0] = encode(mini_mcu_pkg::OP_ADDI, 1, 0, 0, -7);
    prog_tab[6][1] = encode(mini_mcu_pkg::OP_ADDI, 2, 1, 0, 0);
    prog_tab[6][2] = encode(mini_mcu_pkg::OP_BEQ, 0, 1, 2, 2);
    prog_tab[6][3] = encode(mini_mcu_pkg::OP_ADDI, 3, 0, 0, 1);
    prog_tab[6][4] = encode(mini_mcu_pkg::OP_SUB, 4, 1, 2, 0);
    prog_tab[6][5] = encode(mini_mcu_pkg::OP_OR, 4, 4, 3, 0);
    prog_tab[6][6] = encode(mini_mcu_pkg::OP_SW, 0, 0, 4, 'hFF00);

    exp_value_tab = '{32'h0000_0008, 32'hFFFF_FFF7, 32'h0000_0F0F, 32'h0000_0000,
                      32'h0000_1234, 32'h0000_0009, 32'h0000_0000};
    exp_pass_tab  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
  endtask

  // core stop and reset drop together
  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic load_program(input int row);
    for (int i = 0; i < LOAD_WORDS; i++) begin
      @(posedge clk);
      #1;
      prog_we    = 1'b1;
      prog_addr  = mini_mcu_pkg::addr_t'(i);
      prog_wdata = prog_tab[row][i];
    end
    @(posedge clk);
    #1;
    prog_we = 1'b0;
  endtask

  task automatic wait_row_checked(input int row);
    while (rows_done <= row) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_wdata   = '0;
    exp_value    = '0;
    exp_pass     = 1'b0;
    build_programs();
    for (int r = 0; r < ROWS; r++) begin
      apply_reset();
      exp_value = exp_value_tab[r];
      exp_pass  = exp_pass_tab[r];
      load_program(r);
      @(posedge clk);
      #1;
      fetch_enable = 1'b1;
      wait_row_checked(r);
    end
    $display("rows checked %0d, passed %0d, failed %0d", rows_done, rows_passed, rows_failed);
    if ((rows_failed == 0) && (rows_passed == ROWS)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout after %0d cycles, a program never reached its exit store", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/mini_mcu_checker.sv */
// exit result checker
`default_nettype none

module mini_mcu_checker (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fetch_enable_i,
  input  logic                exit_valid_i,
  input  mini_mcu_pkg::word_t exit_value_i,
  input  logic                tests_passed_i,
  input  logic                tests_failed_i,
  input  mini_mcu_pkg::word_t exp_value_i,
  input  logic                exp_pass_i,
  output int                  rows_done_o,
  output int                  rows_passed_o,
  output int                  rows_failed_o
);

  int   done_count = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  logic valid_q    = 1'b0;
  logic idle_bad   = 1'b0;
  logic exit_active;

  assign rows_done_o   = done_count;
  assign rows_passed_o = pass_count;
  assign rows_failed_o = fail_count;

  assign exit_active = exit_valid_i | tests_passed_i | tests_failed_i | (exit_value_i != '0);

  always @(posedge clk_i) begin
    valid_q <= exit_valid_i;

    // core stopped, so reset and loading must leave the exit register clear
    if (rst_n_i && !fetch_enable_i && exit_active && !idle_bad) begin
      $display("FAIL %0t: exit outputs active while the core is stopped", $time);
      idle_bad <= 1'b1;
    end

    // first cycle after exit_valid rose, the exit levels are settled
    if (exit_valid_i && !valid_q) begin
      if (!idle_bad && (exit_value_i == exp_value_i) &&
          (tests_passed_i == exp_pass_i) && (tests_failed_i == !exp_pass_i)) begin
        $display("PASS row %0d: exit value %h", done_count, exit_value_i);
        pass_count <= pass_count + 1;
      end else begin
        $display("FAIL %0t: row %0d exit value %h passed %b failed %b, expected %h pass %b",
                 $time, done_count, exit_value_i, tests_passed_i, tests_failed_i,
                 exp_value_i, exp_pass_i);
        fail_count <= fail_count + 1;
      end
      done_count <= done_count + 1;
      idle_bad   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/mini_mcu.sv */
// mini mcu top level
`default_nettype none

module mini_mcu #(
  parameter mini_mcu_pkg::addr_t BOOT_ADDR = '0,
  parameter int unsigned         RAM_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fetch_enable_i,
  input  logic                prog_we_i,
  input  mini_mcu_pkg::addr_t prog_addr_i,
  input  mini_mcu_pkg::word_t prog_wdata_i,
  output logic                exit_valid_o,
  output mini_mcu_pkg::word_t exit_value_o,
  output logic                tests_passed_o,
  output logic                tests_failed_o
);

  // core to memory
  logic                core_mem_req;
  logic                core_mem_we;
  mini_mcu_pkg::addr_t core_mem_addr;
  mini_mcu_pkg::word_t core_mem_wdata;
  mini_mcu_pkg::word_t core_mem_rdata;

  mini_core #(
    .BOOT_ADDR (BOOT_ADDR)
  ) core_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .mem_req_o      (core_mem_req),
    .mem_we_o       (core_mem_we),
    .mem_addr_o     (core_mem_addr),
    .mem_wdata_o    (core_mem_wdata),
    .mem_rdata_i    (core_mem_rdata)
  );

  mm_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) ram_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .prog_we_i      (prog_we_i),
    .prog_addr_i    (prog_addr_i),
    .prog_wdata_i   (prog_wdata_i),
    .mem_req_i      (core_mem_req),
    .mem_we_i       (core_mem_we),
    .mem_addr_i     (core_mem_addr),
    .mem_wdata_i    (core_mem_wdata),
    .mem_rdata_o    (core_mem_rdata),
    .exit_valid_o   (exit_valid_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_value_o   (exit_value_o)
  );

endmodule

`default_nettype wire

/* src/mm_ram.sv */
// ram with exit register
`default_nettype none

module mm_ram #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fetch_enable_i,
  input  logic                prog_we_i,
  input  mini_mcu_pkg::addr_t prog_addr_i,
  input  mini_mcu_pkg::word_t prog_wdata_i,
  input  logic                mem_req_i,
  input  logic                mem_we_i,
  input  mini_mcu_pkg::addr_t mem_addr_i,
  input  mini_mcu_pkg::word_t mem_wdata_i,
  output mini_mcu_pkg::word_t mem_rdata_o,
  output logic                exit_valid_o,
  output logic                tests_passed_o,
  output logic                tests_failed_o,
  output mini_mcu_pkg::word_t exit_value_o
);

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);

  mini_mcu_pkg::word_t mem_q [RAM_WORDS];
  mini_mcu_pkg::word_t rdata_q;
  logic [IDX_W-1:0]    core_idx;
  logic [IDX_W-1:0]    prog_idx;
  logic                exit_hit;
  logic                core_write;
  logic                prog_write;

  // addresses wrap modulo the depth
  assign core_idx = mem_addr_i[IDX_W-1:0];
  assign prog_idx = prog_addr_i[IDX_W-1:0];

  assign exit_hit   = mem_req_i & mem_we_i & (mem_addr_i == mini_mcu_pkg::EXIT_ADDR);
  assign core_write = mem_req_i & mem_we_i & ~exit_hit;
  assign prog_write = prog_we_i & ~fetch_enable_i;

  always_ff @(posedge clk_i) begin
    if (core_write) begin
      mem_q[core_idx] <= mem_wdata_i;
    end else if (prog_write) begin
      mem_q[prog_idx] <= prog_wdata_i;
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (mem_req_i && !mem_we_i) begin
      rdata_q <= mem_q[core_idx];
    end
  end

  assign mem_rdata_o = rdata_q;

  // first exit store wins, levels stay until reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_o   <= 1'b0;
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
      exit_value_o   <= '0;
    end else if (exit_hit && !exit_valid_o) begin
      exit_valid_o   <= 1'b1;
      tests_passed_o <= (mem_wdata_i == '0);
      tests_failed_o <= (mem_wdata_i != '0);
      exit_value_o   <= mem_wdata_i;
    end
  end

  // loading is only legal while the core is stopped
  no_load_while_running: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    prog_we_i |-> !fetch_enable_i
  );

endmodule

`default_nettype wire

/* src/mini_core.sv */
// multicycle core
`default_nettype none

module mini_core #(
  parameter mini_mcu_pkg::addr_t BOOT_ADDR = '0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fetch_enable_i,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output mini_mcu_pkg::addr_t mem_addr_o,
  output mini_mcu_pkg::word_t mem_wdata_o,
  input  mini_mcu_pkg::word_t mem_rdata_i
);

  mini_mcu_pkg::core_state_e state_q;
  mini_mcu_pkg::addr_t       pc_q;
  mini_mcu_pkg::reg_idx_t    load_rd_q;

  mini_mcu_pkg::reg_idx_t dec_rd, dec_rs1, dec_rs2, wb_rd;
  mini_mcu_pkg::word_t    dec_imm, rs1_data, rs2_data, alu_result;
  mini_mcu_pkg::opcode_e  dec_op;
  mini_mcu_pkg::addr_t    alu_addr, alu_next_pc;
  logic                   dec_reg_we, dec_mem_read, dec_mem_write;
  logic                   in_exec, in_load, wb_we;

  assign in_exec = (state_q == mini_mcu_pkg::ST_EXEC);
  assign in_load = (state_q == mini_mcu_pkg::ST_LOAD);

  // instruction word is only meaningful in ST_EXEC
  instr_decode decode_i (
    .instr_i     (mem_rdata_i),
    .rd_o        (dec_rd),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .imm_o       (dec_imm),
    .op_o        (dec_op),
    .reg_we_o    (dec_reg_we),
    .mem_read_o  (dec_mem_read),
    .mem_write_o (dec_mem_write),
    .branch_o    ()
  );

  alu_execute alu_i (
    .op_i      (dec_op),
    .a_i       (rs1_data),
    .b_i       (rs2_data),
    .imm_i     (dec_imm),
    .pc_i      (pc_q),
    .result_o  (alu_result),
    .addr_o    (alu_addr),
    .next_pc_o (alu_next_pc)
  );

  // loads commit in ST_LOAD with the latched rd
  assign wb_rd = in_load ? load_rd_q : dec_rd;
  assign wb_we = in_load | (in_exec & dec_reg_we & ~dec_mem_read);

  result_writeback wb_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rs1_i        (dec_rs1),
    .rs2_i        (dec_rs2),
    .rd_i         (wb_rd),
    .we_i         (wb_we),
    .sel_load_i   (in_load),
    .alu_result_i (alu_result),
    .load_data_i  (mem_rdata_i),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data)
  );

  // fetch at pc or the data access of the executing LW/SW
  assign mem_req_o   = (state_q == mini_mcu_pkg::ST_FETCH) |
                       (in_exec & (dec_mem_read | dec_mem_write));
  assign mem_we_o    = in_exec & dec_mem_write;
  assign mem_addr_o  = in_exec ? alu_addr : pc_q;
  assign mem_wdata_o = rs2_data;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= mini_mcu_pkg::ST_IDLE;
      pc_q    <= BOOT_ADDR;
    end else begin
      case (state_q)
        mini_mcu_pkg::ST_IDLE: begin
          if (fetch_enable_i) begin
            state_q <= mini_mcu_pkg::ST_FETCH;
          end
        end
        mini_mcu_pkg::ST_FETCH: begin
          state_q <= mini_mcu_pkg::ST_EXEC;
        end
        mini_mcu_pkg::ST_EXEC: begin
          // the alu applies the BEQ rule
          pc_q <= alu_next_pc;
          if (dec_mem_read) begin
            state_q <= mini_mcu_pkg::ST_LOAD;
          end else begin
            state_q <= fetch_enable_i ? mini_mcu_pkg::ST_FETCH : mini_mcu_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= fetch_enable_i ? mini_mcu_pkg::ST_FETCH : mini_mcu_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_exec) begin
      load_rd_q <= dec_rd;
    end
  end

  we_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_we_o |-> mem_req_o
  );

  load_after_exec: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    in_load |-> ($past(state_q) == mini_mcu_pkg::ST_EXEC)
  );

endmodule

`default_nettype wire

/* src/result_writeback.sv */
// register file and writeback
`default_nettype none

module result_writeback (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::reg_idx_t rs1_i,
  input  mini_mcu_pkg::reg_idx_t rs2_i,
  input  mini_mcu_pkg::reg_idx_t rd_i,
  input  logic                   we_i,
  input  logic                   sel_load_i,
  input  mini_mcu_pkg::word_t    alu_result_i,
  input  mini_mcu_pkg::word_t    load_data_i,
  output mini_mcu_pkg::word_t    rs1_data_o,
  output mini_mcu_pkg::word_t    rs2_data_o
);

  mini_mcu_pkg::word_t regs_q [8];
  mini_mcu_pkg::word_t wb_data;

  // load data only during the extra load cycle
  assign wb_data = sel_load_i ? load_data_i : alu_result_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 8; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      // x0 never takes a write
      regs_q[rd_i] <= wb_data;
    end
  end

  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

  // a write aimed at x0 leaves it reading zero
  x0_stays_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (we_i && (rd_i == '0)) |=> (regs_q[0] == '0)
  );

endmodule

`default_nettype wire

/* src/alu_execute.sv */
// alu and branch unit
`default_nettype none

module alu_execute (
  input  mini_mcu_pkg::opcode_e op_i,
  input  mini_mcu_pkg::word_t   a_i,
  input  mini_mcu_pkg::word_t   b_i,
  input  mini_mcu_pkg::word_t   imm_i,
  input  mini_mcu_pkg::addr_t   pc_i,
  output mini_mcu_pkg::word_t   result_o,
  output mini_mcu_pkg::addr_t   addr_o,
  output mini_mcu_pkg::addr_t   next_pc_o
);

  mini_mcu_pkg::word_t sum_imm;
  logic                branch_taken;

  // shared by ADDI and the load/store address
  assign sum_imm = a_i + imm_i;
  assign addr_o  = sum_imm[15:0];

  always_comb begin
    case (op_i)
      mini_mcu_pkg::OP_ADDI: result_o = sum_imm;
      mini_mcu_pkg::OP_ADD:  result_o = a_i + b_i;
      mini_mcu_pkg::OP_SUB:  result_o = a_i - b_i;
      mini_mcu_pkg::OP_AND:  result_o = a_i & b_i;
      mini_mcu_pkg::OP_OR:   result_o = a_i | b_i;
      mini_mcu_pkg::OP_XOR:  result_o = a_i ^ b_i;
      default:               result_o = '0;
    endcase
  end

  // BEQ offset is relative to the branch itself
  assign branch_taken = (op_i == mini_mcu_pkg::OP_BEQ) && (a_i == b_i);
  assign next_pc_o    = branch_taken ? pc_i + imm_i[15:0] : pc_i + 16'd1;

endmodule

`default_nettype wire

/* src/instr_decode.sv */
// instruction decoder
`default_nettype none

module instr_decode (
  input  mini_mcu_pkg::word_t    instr_i,
  output mini_mcu_pkg::reg_idx_t rd_o,
  output mini_mcu_pkg::reg_idx_t rs1_o,
  output mini_mcu_pkg::reg_idx_t rs2_o,
  output mini_mcu_pkg::word_t    imm_o,
  output mini_mcu_pkg::opcode_e  op_o,
  output logic                   reg_we_o,
  output logic                   mem_read_o,
  output logic                   mem_write_o,
  output logic                   branch_o
);

  // unknown codes are carried as-is and decode to no flags
  assign op_o  = mini_mcu_pkg::opcode_e'(instr_i[mini_mcu_pkg::OPCODE_LSB +: 4]);
  assign rd_o  = instr_i[mini_mcu_pkg::RD_LSB +: 3];
  assign rs1_o = instr_i[mini_mcu_pkg::RS1_LSB +: 3];
  assign rs2_o = instr_i[mini_mcu_pkg::RS2_LSB +: 3];

  // sign extend the low immediate field
  assign imm_o = {{(32 - mini_mcu_pkg::IMM_W){instr_i[mini_mcu_pkg::IMM_W-1]}},
                  instr_i[mini_mcu_pkg::IMM_W-1:0]};

  always_comb begin
    reg_we_o    = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    branch_o    = 1'b0;
    case (op_o)
      mini_mcu_pkg::OP_ADDI,
      mini_mcu_pkg::OP_ADD,
      mini_mcu_pkg::OP_SUB,
      mini_mcu_pkg::OP_AND,
      mini_mcu_pkg::OP_OR,
      mini_mcu_pkg::OP_XOR: begin
        reg_we_o = 1'b1;
      end
      mini_mcu_pkg::OP_LW: begin
        // rd is written later, from the load data
        reg_we_o   = 1'b1;
        mem_read_o = 1'b1;
      end
      mini_mcu_pkg::OP_SW: begin
        mem_write_o = 1'b1;
      end
      mini_mcu_pkg::OP_BEQ: begin
        branch_o = 1'b1;
      end
      default: begin
        reg_we_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/mini_mcu_pkg.sv */
// mini mcu shared types
`default_nettype none

package mini_mcu_pkg;

  // data and instruction word
  typedef logic [31:0] word_t;

  // word address for pc, RAM and the exit map
  typedef logic [15:0] addr_t;

  // register index, x0 to x7
  typedef logic [2:0] reg_idx_t;

  // opcode in instruction bits 31:28, anything else is a no-op
  typedef enum logic [3:0] {
    OP_ADDI = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_AND  = 4'h4,
    OP_OR   = 4'h5,
    OP_XOR  = 4'h6,
    OP_LW   = 4'h7,
    OP_SW   = 4'h8,
    OP_BEQ  = 4'h9
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_LOAD
  } core_state_e;

  // instruction field positions
  localparam int unsigned OPCODE_LSB = 28;
  localparam int unsigned RD_LSB     = 25;
  localparam int unsigned RS1_LSB    = 22;
  localparam int unsigned RS2_LSB    = 19;
  localparam int unsigned IMM_W      = 16;

  // a store here ends the program
  localparam addr_t EXIT_ADDR = 16'hFF00;

endpackage

`default_nettype wire
